/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_mycpu
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
hw/la32_pkg.sv
hw/la32_decoder.sv
hw/la32_alu.sv
hw/la32_regfile.sv
hw/mycpu_top.sv
verification/tb_sram_model.sv
verification/tb_mycpu.sv

/* hw/la32_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module la32_alu import la32_pkg::*; (
    input  alu_op_t alu_op,
    input  word_t   alu_src1,
    input  word_t   alu_src2,
    output word_t   alu_result
);

    word_t    add_res;
    word_t    sub_res;
    word_t    slt_res;
    word_t    sltu_res;
    word_t    and_res;
    word_t    nor_res;
    word_t    or_res;
    word_t    xor_res;
    word_t    sll_res;
    word_t    srl_res;
    word_t    sra_res;
    logic [4:0] shamt;

    assign shamt = alu_src2[4:0];

    assign add_res  = alu_src1 + alu_src2;
    assign sub_res  = alu_src1 - alu_src2;
    assign slt_res  = {31'b0, $signed(alu_src1) < $signed(alu_src2)};
    assign sltu_res = {31'b0, alu_src1 < alu_src2};
    assign and_res  = alu_src1 & alu_src2;
    assign nor_res  = ~(alu_src1 | alu_src2);
    assign or_res   = alu_src1 | alu_src2;
    assign xor_res  = alu_src1 ^ alu_src2;
    assign sll_res  = alu_src1 << shamt;
    assign srl_res  = alu_src1 >> shamt;
    assign sra_res  = word_t'($signed(alu_src1) >>> shamt);

    // one-hot and-or select
    assign alu_result = ({32{alu_op[ALU_ADD]}}  & add_res)
                      | ({32{alu_op[ALU_SUB]}}  & sub_res)
                      | ({32{alu_op[ALU_SLT]}}  & slt_res)
                      | ({32{alu_op[ALU_SLTU]}} & sltu_res)
                      | ({32{alu_op[ALU_AND]}}  & and_res)
                      | ({32{alu_op[ALU_NOR]}}  & nor_res)
                      | ({32{alu_op[ALU_OR]}}   & or_res)
                      | ({32{alu_op[ALU_XOR]}}  & xor_res)
                      | ({32{alu_op[ALU_SLL]}}  & sll_res)
                      | ({32{alu_op[ALU_SRL]}}  & srl_res)
                      | ({32{alu_op[ALU_SRA]}}  & sra_res)
                      | ({32{alu_op[ALU_LUI]}}  & alu_src2);

endmodule

`default_nettype wire

/* hw/la32_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module la32_decoder import la32_pkg::*; (
    input  word_t    inst,
    input  word_t    rj_value,
    input  word_t    rkd_value,
    input  word_t    pc,
    output alu_op_t  alu_op,
    output logic     src1_is_pc,
    output logic     src2_sel_imm,
    output logic     src2_is_4,
    output logic     res_from_mem,
    output logic     gr_we,
    output logic     mem_we,
    output logic     is_load,
    output logic     is_store,
    output logic     is_branch_only,
    output logic     br_taken,
    output word_t    br_target,
    output word_t    imm,
    output reg_idx_t dest,
    output reg_idx_t rf_raddr1,
    output reg_idx_t rf_raddr2
);

    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    reg_idx_t    rd, rj, rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    word_t       offs16, offs26;

    logic grp_3r, grp_sh;
    logic inst_add_w, inst_sub_w, inst_slt, inst_sltu, inst_nor, inst_and, inst_or, inst_xor;
    logic inst_slli_w, inst_srli_w, inst_srai_w, inst_addi_w, inst_lu12i_w;
    logic inst_ld_w, inst_st_w, inst_jirl, inst_b, inst_bl, inst_beq, inst_bne;
    logic src_reg_is_rd;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};     // offs[25:16] sits in the low bits

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction match
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign grp_3r = (op_31_26 == OP_31_26_ZERO) && (op_25_22 == OP_25_22_ALU3R)
                 && (op_21_20 == OP_21_20_ALU3R);
    assign grp_sh = (op_31_26 == OP_31_26_ZERO) && (op_25_22 == OP_25_22_SHIFT)
                 && (op_21_20 == OP_21_20_SHIFT);

    assign inst_add_w   = grp_3r && (op_19_15 == OP_19_15_ADD_W);
    assign inst_sub_w   = grp_3r && (op_19_15 == OP_19_15_SUB_W);
    assign inst_slt     = grp_3r && (op_19_15 == OP_19_15_SLT);
    assign inst_sltu    = grp_3r && (op_19_15 == OP_19_15_SLTU);
    assign inst_nor     = grp_3r && (op_19_15 == OP_19_15_NOR);
    assign inst_and     = grp_3r && (op_19_15 == OP_19_15_AND);
    assign inst_or      = grp_3r && (op_19_15 == OP_19_15_OR);
    assign inst_xor     = grp_3r && (op_19_15 == OP_19_15_XOR);
    assign inst_slli_w  = grp_sh && (op_19_15 == OP_19_15_SLLI_W);
    assign inst_srli_w  = grp_sh && (op_19_15 == OP_19_15_SRLI_W);
    assign inst_srai_w  = grp_sh && (op_19_15 == OP_19_15_SRAI_W);
    assign inst_addi_w  = (op_31_26 == OP_31_26_ZERO) && (op_25_22 == OP_25_22_ADDI);
    assign inst_lu12i_w = (op_31_26 == OP_31_26_LU12I) && !inst[25];
    assign inst_ld_w    = (op_31_26 == OP_31_26_MEM) && (op_25_22 == OP_25_22_LD_W);
    assign inst_st_w    = (op_31_26 == OP_31_26_MEM) && (op_25_22 == OP_25_22_ST_W);
    assign inst_jirl    = (op_31_26 == OP_31_26_JIRL);
    assign inst_b       = (op_31_26 == OP_31_26_B);
    assign inst_bl      = (op_31_26 == OP_31_26_BL);
    assign inst_beq     = (op_31_26 == OP_31_26_BEQ);
    assign inst_bne     = (op_31_26 == OP_31_26_BNE);

    always_comb begin
        alu_op           = '0;
        alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                         | inst_bl | inst_jirl;     // link is pc + 4
        alu_op[ALU_SUB]  = inst_sub_w;
        alu_op[ALU_SLT]  = inst_slt;
        alu_op[ALU_SLTU] = inst_sltu;
        alu_op[ALU_AND]  = inst_and;
        alu_op[ALU_NOR]  = inst_nor;
        alu_op[ALU_OR]   = inst_or;
        alu_op[ALU_XOR]  = inst_xor;
        alu_op[ALU_SLL]  = inst_slli_w;
        alu_op[ALU_SRL]  = inst_srli_w;
        alu_op[ALU_SRA]  = inst_srai_w;
        alu_op[ALU_LUI]  = inst_lu12i_w;
    end

    // immediates: ui5 for shifts, si20 for lu12i.w, si12 otherwise
    assign imm = grp_sh       ? {27'b0, rk} :
                 inst_lu12i_w ? {i20, 12'b0} :
                                {{20{i12[11]}}, i12};
    assign offs16 = {{14{i16[15]}}, i16, 2'b0};
    assign offs26 = {{4{i26[25]}}, i26, 2'b0};

    assign src1_is_pc     = inst_bl | inst_jirl;
    assign src2_is_4      = inst_bl | inst_jirl;
    assign src2_sel_imm   = grp_sh | inst_addi_w | inst_lu12i_w | inst_ld_w | inst_st_w;
    assign is_load        = inst_ld_w;
    assign is_store       = inst_st_w;
    assign res_from_mem   = inst_ld_w;
    assign mem_we         = inst_st_w;
    assign is_branch_only = inst_b | inst_beq | inst_bne;     // done in ID
    assign gr_we          = !(inst_st_w | inst_b | inst_beq | inst_bne);

    assign src_reg_is_rd = inst_beq | inst_bne | inst_st_w;
    assign rf_raddr1     = rj;
    assign rf_raddr2     = src_reg_is_rd ? rd : rk;
    assign dest          = inst_bl ? reg_idx_t'(5'd1) : rd;

    assign br_taken  = (inst_beq && (rj_value == rkd_value))
                    || (inst_bne && (rj_value != rkd_value))
                    || inst_b || inst_bl || inst_jirl;
    assign br_target = inst_jirl           ? rj_value + offs16 :
                       (inst_b || inst_bl) ? pc + offs26 :
                                             pc + offs16;

endmodule

`default_nettype wire

/* hw/la32_pkg.sv */
`default_nettype none

package la32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alu operation, one-hot bit positions
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;       // passes src2 through

    typedef enum logic [2:0] {
        ST_IF  = 3'd0,
        ST_ID  = 3'd1,
        ST_EXE = 3'd2,
        ST_MEM = 3'd3,
        ST_WB  = 3'd4
    } cpu_state_t;

    localparam word_t RESET_PC = 32'h1c00_0000;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [5:0] OP_31_26_ZERO  = 6'h00;    // 3r, shifts, addi.w
    localparam logic [5:0] OP_31_26_LU12I = 6'h05;    // also needs inst[25] == 0
    localparam logic [5:0] OP_31_26_MEM   = 6'h0a;
    localparam logic [5:0] OP_31_26_JIRL  = 6'h13;
    localparam logic [5:0] OP_31_26_B     = 6'h14;
    localparam logic [5:0] OP_31_26_BL    = 6'h15;
    localparam logic [5:0] OP_31_26_BEQ   = 6'h16;
    localparam logic [5:0] OP_31_26_BNE   = 6'h17;

    localparam logic [3:0] OP_25_22_ALU3R = 4'h0;
    localparam logic [3:0] OP_25_22_SHIFT = 4'h1;
    localparam logic [3:0] OP_25_22_LD_W  = 4'h2;
    localparam logic [3:0] OP_25_22_ST_W  = 4'h6;
    localparam logic [3:0] OP_25_22_ADDI  = 4'ha;

    localparam logic [1:0] OP_21_20_SHIFT = 2'h0;
    localparam logic [1:0] OP_21_20_ALU3R = 2'h1;

    localparam logic [4:0] OP_19_15_ADD_W  = 5'h00;
    localparam logic [4:0] OP_19_15_SUB_W  = 5'h02;
    localparam logic [4:0] OP_19_15_SLT    = 5'h04;
    localparam logic [4:0] OP_19_15_SLTU   = 5'h05;
    localparam logic [4:0] OP_19_15_NOR    = 5'h08;
    localparam logic [4:0] OP_19_15_AND    = 5'h09;
    localparam logic [4:0] OP_19_15_OR     = 5'h0a;
    localparam logic [4:0] OP_19_15_XOR    = 5'h0b;
    localparam logic [4:0] OP_19_15_SLLI_W = 5'h01;
    localparam logic [4:0] OP_19_15_SRLI_W = 5'h09;
    localparam logic [4:0] OP_19_15_SRAI_W = 5'h11;

endpackage

`default_nettype wire

/* hw/la32_regfile.sv */
`timescale 1ns/10ps
`default_nettype none

module la32_regfile import la32_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  reg_idx_t waddr,
    input  logic     we,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [1:31];     // r0 has no storage

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* hw/mycpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mycpu_top import la32_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    // instruction sram
    output word_t       inst_sram_addr,
    input  word_t       inst_sram_rdata,
    // data sram
    output logic        data_sram_we,
    output word_t       data_sram_addr,
    output word_t       data_sram_wdata,
    input  word_t       data_sram_rdata,
    // trace
    output word_t       debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output reg_idx_t    debug_wb_rf_wnum,
    output word_t       debug_wb_rf_wdata
);

    cpu_state_t state, state_next;

    word_t    pc;
    word_t    npc;          // pc of the next instruction, chosen in ID
    word_t    ir;
    word_t    exe_res;
    word_t    st_data;
    word_t    inst_cur;
    word_t    nextpc;

    alu_op_t  alu_op;
    logic     src1_is_pc, src2_sel_imm, src2_is_4;
    logic     res_from_mem, gr_we, mem_we;
    logic     is_load, is_store, is_branch_only;
    logic     br_taken;
    word_t    br_target, imm;
    reg_idx_t dest, rf_raddr1, rf_raddr2;

    word_t    rf_rdata1, rf_rdata2;
    logic     rf_we;
    word_t    wb_data;
    word_t    alu_src1, alu_src2, alu_result;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch and decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign inst_sram_addr = pc;
    // the fetched word is only on the sram bus during ID
    assign inst_cur = (state == ST_ID) ? inst_sram_rdata : ir;
    assign nextpc   = br_taken ? br_target : pc + 32'd4;

    la32_decoder u_decoder (
        .inst           (inst_cur),
        .rj_value       (rf_rdata1),
        .rkd_value      (rf_rdata2),
        .pc             (pc),
        .alu_op         (alu_op),
        .src1_is_pc     (src1_is_pc),
        .src2_sel_imm   (src2_sel_imm),
        .src2_is_4      (src2_is_4),
        .res_from_mem   (res_from_mem),
        .gr_we          (gr_we),
        .mem_we         (mem_we),
        .is_load        (is_load),
        .is_store       (is_store),
        .is_branch_only (is_branch_only),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .imm            (imm),
        .dest           (dest),
        .rf_raddr1      (rf_raddr1),
        .rf_raddr2      (rf_raddr2)
    );

    la32_regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .waddr  (dest),
        .we     (rf_we),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    assign alu_src1 = src1_is_pc   ? pc      : rf_rdata1;
    assign alu_src2 = src2_is_4    ? 32'd4   :
                      src2_sel_imm ? imm     : rf_rdata2;

    la32_alu u_alu (
        .alu_op     (alu_op),
        .alu_src1   (alu_src1),
        .alu_src2   (alu_src2),
        .alu_result (alu_result)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // state machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (state)
            ST_IF:   state_next = ST_ID;
            ST_ID:   state_next = is_branch_only ? ST_IF : ST_EXE;
            ST_EXE:  state_next = (is_load || is_store) ? ST_MEM : ST_WB;
            ST_MEM:  state_next = is_load ? ST_WB : ST_IF;
            ST_WB:   state_next = ST_IF;
            default: state_next = ST_IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= ST_IF;
            pc           <= RESET_PC;
            data_sram_we <= 1'b0;
        end else begin
            state        <= state_next;
            data_sram_we <= (state == ST_EXE) && mem_we;     // high for the MEM cycle only
            if (state == ST_ID && is_branch_only) begin
                pc <= nextpc;
            end else if (state != ST_ID && state_next == ST_IF) begin
                pc <= npc;      // retire, pc held until here for the trace
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_ID) begin
            ir  <= inst_sram_rdata;
            npc <= nextpc;
        end
        if (state == ST_EXE) begin
            exe_res <= alu_result;
            st_data <= rf_rdata2;
        end
    end

    assign data_sram_addr  = exe_res;
    assign data_sram_wdata = st_data;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback and trace
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign wb_data = res_from_mem ? data_sram_rdata : exe_res;
    assign rf_we   = (state == ST_WB) && gr_we && (dest != '0);     // r0 writes stay silent

    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = dest;
    assign debug_wb_rf_wdata = wb_data;

endmodule

`default_nettype wire

/* verification/tb_mycpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mycpu import la32_pkg::*; ();

    localparam int TOTAL_INSTR = 46;
    localparam int CYCLE_LIMIT = 6 * TOTAL_INSTR + 200;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    word_t      inst_sram_addr, inst_sram_rdata;
    logic       data_sram_we;
    word_t      data_sram_addr, data_sram_wdata, data_sram_rdata;
    word_t      debug_wb_pc, debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_we;
    reg_idx_t   debug_wb_rf_wnum;

    integer seed = 69;
    int     cycle_count = 0;
    int     mismatch_count = 0;
    int     missing_count = 0;

    word_t    prog_q[$];
    word_t    exp_pc_q[$];
    reg_idx_t exp_num_q[$];
    word_t    exp_val_q[$];
    word_t    exp_st_addr_q[$];
    word_t    exp_st_data_q[$];
    word_t    st_addr_q[$];
    word_t    st_data_q[$];
    word_t    mdl [0:31];          // register values as the program should leave them

    always #10 clk = ~clk;

    mycpu_top UUT (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_sram_model imem (.clk(clk), .addr(inst_sram_addr), .we(1'b0), .wdata(32'h0),
                        .rdata(inst_sram_rdata));
    tb_sram_model dmem (.clk(clk), .addr(data_sram_addr), .we(data_sram_we),
                        .wdata(data_sram_wdata), .rdata(data_sram_rdata));

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (data_sram_we) begin
            st_addr_q.push_back(data_sram_addr);     // every write cycle is recorded
            st_data_q.push_back(data_sram_wdata);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders and reference rules
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t enc_3r(logic [4:0] op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        return {OP_31_26_ZERO, OP_25_22_ALU3R, OP_21_20_ALU3R, op, rk, rj, rd};
    endfunction

    function automatic word_t enc_shift(logic [4:0] op, reg_idx_t rd, reg_idx_t rj,
                                        logic [4:0] sa);
        return {OP_31_26_ZERO, OP_25_22_SHIFT, OP_21_20_SHIFT, op, sa, rj, rd};
    endfunction

    function automatic word_t enc_ri12(logic [5:0] op_hi, logic [3:0] op_lo, reg_idx_t rd,
                                       reg_idx_t rj, logic [11:0] si);
        return {op_hi, op_lo, si, rj, rd};
    endfunction

    function automatic word_t enc_lu12i(reg_idx_t rd, logic [19:0] si);
        return {OP_31_26_LU12I, 1'b0, si, rd};
    endfunction

    function automatic word_t enc_br16(logic [5:0] op, reg_idx_t rj, reg_idx_t rd,
                                       logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic word_t enc_br26(logic [5:0] op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic word_t ref_3r(logic [4:0] op, word_t a, word_t b);
        case (op)
            OP_19_15_ADD_W: return a + b;
            OP_19_15_SUB_W: return a - b;
            OP_19_15_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_19_15_SLTU:  return (a < b) ? 32'd1 : 32'd0;
            OP_19_15_NOR:   return ~(a | b);
            OP_19_15_AND:   return a & b;
            OP_19_15_OR:    return a | b;
            default:        return a ^ b;
        endcase
    endfunction

    function automatic word_t ref_shift(logic [4:0] op, word_t a, logic [4:0] sa);
        case (op)
            OP_19_15_SLLI_W: return a << sa;
            OP_19_15_SRLI_W: return a >> sa;
            default:         return word_t'($signed(a) >>> sa);
        endcase
    endfunction

    function automatic word_t cur_pc();
        return RESET_PC + 32'(4 * prog_q.size());
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // program building and running
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic begin_program();
        prog_q.delete();
        exp_pc_q.delete();
        exp_num_q.delete();
        exp_val_q.delete();
        exp_st_addr_q.delete();
        exp_st_data_q.delete();
        for (int i = 0; i < 32; i++) begin
            mdl[i] = '0;
        end
    endtask

    task automatic emit(input word_t inst);
        prog_q.push_back(inst);
    endtask

    task automatic emit_wr(input word_t inst, input reg_idx_t rd, input word_t value);
        if (rd != '0) begin       // r0 writes leave no trace
            exp_pc_q.push_back(cur_pc());
            exp_num_q.push_back(rd);
            exp_val_q.push_back(value);
            mdl[rd] = value;
        end
        prog_q.push_back(inst);
    endtask

    task automatic load_const(input reg_idx_t rd, input word_t value);
        logic [11:0] lo;
        logic [19:0] hi;
        word_t       upper;
        lo    = value[11:0];
        hi    = value[31:12] + {19'b0, lo[11]};     // addi sign-extends lo
        upper = {hi, 12'b0};
        emit_wr(enc_lu12i(rd, hi), rd, upper);
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, rd, rd, lo), rd,
                upper + {{20{lo[11]}}, lo});
    endtask

    task automatic check_reset_state(input word_t addr, input logic we, input logic [3:0] rf_we);
        if (addr !== RESET_PC || we !== 1'b0 || rf_we !== 4'h0) begin
            $display("MISMATCH at %0t: in reset addr %h we %b rf_we %h", $time, addr, we, rf_we);
            mismatch_count++;
        end
    endtask

    task automatic check_trace(input word_t pc, input reg_idx_t num, input word_t val,
                               input word_t exp_pc, input reg_idx_t exp_num,
                               input word_t exp_val);
        if (pc !== exp_pc || num !== exp_num || val !== exp_val) begin
            $display("MISMATCH at %0t: trace pc %h r%0d=%h, expected pc %h r%0d=%h",
                     $time, pc, num, val, exp_pc, exp_num, exp_val);
            mismatch_count++;
        end
    endtask

    task automatic check_store(input word_t addr, input word_t data,
                               input word_t exp_addr, input word_t exp_data);
        if (addr !== exp_addr || data !== exp_data) begin
            $display("MISMATCH at %0t: store [%h]=%h, expected [%h]=%h",
                     $time, addr, data, exp_addr, exp_data);
            mismatch_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (15) @(posedge clk);
        @(negedge clk);
        check_reset_state(inst_sram_addr, data_sram_we, debug_wb_rf_we);
        @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_trace(output logic found);
        int waited;
        found  = 1'b0;
        waited = 0;
        while (!found && waited < 8) begin
            @(negedge clk);
            waited++;
            found = (debug_wb_rf_we == 4'hf);
        end
    endtask

    task automatic run_program(input string name);
        logic found;
        @(negedge clk);
        for (int i = 0; i < 1024; i++) begin
            imem.load_word(i, (i < prog_q.size()) ? prog_q[i] : 32'h0);
        end
        st_addr_q.delete();
        st_data_q.delete();
        apply_reset();
        foreach (exp_pc_q[i]) begin
            wait_trace(found);
            if (!found) begin
                $display("ERROR: %s, no register write within 8 cycles (event %0d)", name, i);
                missing_count++;
                return;
            end
            check_trace(debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata,
                        exp_pc_q[i], exp_num_q[i], exp_val_q[i]);
        end
        if (st_addr_q.size() != exp_st_addr_q.size()) begin
            $display("MISMATCH at %0t: %s saw %0d store cycles, expected %0d", $time, name,
                     st_addr_q.size(), exp_st_addr_q.size());
            mismatch_count++;
        end else begin
            foreach (st_addr_q[i]) begin
                check_store(st_addr_q[i], st_data_q[i], exp_st_addr_q[i], exp_st_data_q[i]);
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_fetch();
        begin_program();
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 1, 0, 12'd5), 1, 32'd5);
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 2, 1, 12'hfff), 2, mdl[1] - 32'd1);
        run_program("reset");
    endtask

    task automatic test_alu_ops();
        logic [4:0] ops [8];
        ops = '{OP_19_15_ADD_W, OP_19_15_SUB_W, OP_19_15_SLT, OP_19_15_SLTU,
                OP_19_15_AND, OP_19_15_OR, OP_19_15_XOR, OP_19_15_NOR};
        begin_program();
        load_const(4, $random(seed));
        load_const(5, $random(seed));
        for (int i = 0; i < 8; i++) begin
            emit_wr(enc_3r(ops[i], reg_idx_t'(7 + i), 4, 5), reg_idx_t'(7 + i),
                    ref_3r(ops[i], mdl[4], mdl[5]));
        end
        run_program("alu");
    endtask

    task automatic test_shifts();
        logic [4:0] sa;
        logic [4:0] ops [3];
        ops = '{OP_19_15_SLLI_W, OP_19_15_SRLI_W, OP_19_15_SRAI_W};
        begin_program();
        load_const(4, $random(seed) | 32'h8000_0000);      // negative operand
        for (int i = 0; i < 3; i++) begin
            sa = 5'($random(seed));
            emit_wr(enc_shift(ops[i], reg_idx_t'(6 + i), 4, sa), reg_idx_t'(6 + i),
                    ref_shift(ops[i], mdl[4], sa));
        end
        emit_wr(enc_shift(OP_19_15_SRAI_W, 9, 4, 5'd31), 9,
                ref_shift(OP_19_15_SRAI_W, mdl[4], 5'd31));
        run_program("shift");
    endtask

    task automatic test_load_store();
        begin_program();
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 4, 0, 12'h100), 4, 32'h100);
        load_const(5, $random(seed));
        emit(enc_ri12(OP_31_26_MEM, OP_25_22_ST_W, 5, 4, 12'h008));
        exp_st_addr_q.push_back(mdl[4] + 32'h8);
        exp_st_data_q.push_back(mdl[5]);
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 6, 0, 12'd1), 6, 32'd1);
        emit_wr(enc_ri12(OP_31_26_MEM, OP_25_22_LD_W, 7, 4, 12'h008), 7, mdl[5]);
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 0, 5, 12'd3), 0, '0);
        emit_wr(enc_3r(OP_19_15_SUB_W, 8, 5, 0), 8, ref_3r(OP_19_15_SUB_W, mdl[5], 32'h0));
        run_program("memory");
        check_store(32'h108, dmem.peek_word(32'h108 >> 2), 32'h108, mdl[5]);
    endtask

    task automatic test_branches();
        begin_program();
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 4, 0, 12'd7), 4, 32'd7);
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 5, 0, 12'd7), 5, 32'd7);
        emit(enc_br16(OP_31_26_BEQ, 4, 5, 16'd2));                         // taken
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 6, 0, 12'd1));         // skipped
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 6, 0, 12'd2), 6, 32'd2);
        emit(enc_br16(OP_31_26_BNE, 4, 6, 16'd2));                         // taken
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 7, 0, 12'd1));
        emit(enc_br16(OP_31_26_BEQ, 4, 6, 16'd2));                         // falls through
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 7, 0, 12'd3), 7, 32'd3);
        emit_wr(enc_br26(OP_31_26_BL, 26'd2), 1, cur_pc() + 32'd4);
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 8, 0, 12'd1));
        emit_wr(enc_lu12i(9, 20'h1c000), 9, 32'h1c00_0000);
        emit_wr(enc_br16(OP_31_26_JIRL, 9, 10, 16'd15), 10, cur_pc() + 32'd4);  // to index 15
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 8, 0, 12'd2));
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 8, 0, 12'd3));
        emit(enc_br26(OP_31_26_B, 26'd2));
        emit(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 11, 0, 12'd1));
        emit_wr(enc_ri12(OP_31_26_ZERO, OP_25_22_ADDI, 11, 0, 12'd9), 11, 32'd9);
        run_program("branch");
    endtask

    initial begin
        test_reset_fetch();
        test_alu_ops();
        test_shifts();
        test_load_store();
        test_branches();
        $display("errors: %0d mismatches, %0d missing trace events",
                 mismatch_count, missing_count);
        if (mismatch_count == 0 && missing_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/tb_sram_model.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sram_model import la32_pkg::*; (
    input  logic  clk,
    input  word_t addr,
    input  logic  we,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [0:1023];       // indexed by addr[11:2]

    initial begin
        rdata = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = word_t'(i) * 32'h9e37_79b9;
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[addr[11:2]] <= wdata;
        end
        rdata <= mem[addr[11:2]];      // one-cycle read latency
    end

    task automatic load_word(input int idx, input word_t value);
        mem[idx] = value;
    endtask

    function automatic word_t peek_word(input int idx);
        return mem[idx];
    endfunction

endmodule

`default_nettype wire
